/* Bender.yml */
package:
  name: lsq_subsystem

sources:
  # packages first, every RTL file imports them
  - logic/ooo_types_pkg.sv
  - logic/lsq_cfg_pkg.sv
  - logic/mem_issue_if.sv
  - logic/dispatch_slot.sv
  - logic/load_store_queue.sv
  - logic/data_memory_unit.sv
  - logic/lsq_top.sv
  - target: simulation
    files:
      - verification/lsq_tb.sv

/* logic/data_memory_unit.sv */
`timescale 1ns/1ns
`default_nettype none

// word RAM behind the queue
// stores complete at their transfer edge, loads return LOAD_LAT cycles later
module data_memory_unit import ooo_types_pkg::*, lsq_cfg_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,

   mem_issue_if.mem issue,

   output logic     load_valid,
   output tag_t     load_tag,
   output word_t    load_data
);

   word_t                ram [RAM_WORDS];
   logic [RAM_IDX_W-1:0] ram_idx;

   logic     xfer;
   logic     store_go;
   logic     load_start;

   // cycles left until a started load shows its result, 0 when idle
   lat_cnt_t lat_cnt;

   // read data and tag wait here while the load is in flight
   tag_t     hold_tag;
   word_t    hold_data;

   logic     load_valid_q;
   tag_t     load_tag_q;
   word_t    load_data_q;

   // byte address, word index taken above the two byte bits
   assign ram_idx = issue.addr[RAM_IDX_W+1:2];

   // back-pressure during all but the final cycle of a load
   assign issue.done = (lat_cnt <= lat_cnt_t'(1));

   assign xfer       = issue.ready && issue.done;
   assign store_go   = xfer && (issue.op == mem_store);
   assign load_start = xfer && (issue.op == mem_load);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lat_cnt      <= '0;
         load_valid_q <= 1'b0;
      end else begin
         // the result goes out on the edge that ends the last count
         load_valid_q <= (lat_cnt == lat_cnt_t'(1));
         if (load_start) begin
            lat_cnt <= lat_cnt_t'(LOAD_LAT);
         end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (store_go) begin
         ram[ram_idx] <= issue.data;
      end
      // a load sees every store transferred before it
      if (load_start) begin
         hold_tag  <= issue.rt_tag;
         hold_data <= ram[ram_idx];
      end
      // a load starting in the final cycle of the previous one only
      // refills the hold registers, the output takes the older values
      if (lat_cnt == lat_cnt_t'(1)) begin
         load_tag_q  <= hold_tag;
         load_data_q <= hold_data;
      end
   end

   assign load_valid = load_valid_q;
   assign load_tag   = load_tag_q;
   assign load_data  = load_data_q;

   // addresses come from the queue's adder, they must hit a whole word
   // inside the RAM
   a_addr_ok: assert property (
      @(posedge clk) disable iff (!rst_n)
      xfer |-> ((issue.addr[1:0] == 2'b00) &&
                (issue.addr[XLEN-1:RAM_IDX_W+2] == '0))
   );

endmodule

`default_nettype wire

/* logic/dispatch_slot.sv */
`timescale 1ns/1ns
`default_nettype none

// one-entry holding register between dispatch and the load/store queue
// it keeps watching the CDB, so an operand broadcast while the entry waits
// here is not lost
module dispatch_slot import ooo_types_pkg::*, lsq_cfg_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,

   input  logic       dispatch_en,
   input  mem_op_e    dispatch_op,
   input  offset_t    dispatch_offset,
   input  tag_t       dispatch_rs_tag,
   input  tag_t       dispatch_rt_tag,
   input  word_t      dispatch_rs_data,
   input  word_t      dispatch_rt_data,
   input  logic       dispatch_rs_valid,
   input  logic       dispatch_rt_valid,
   output logic       dispatch_ready,

   input  tag_t       cdb_tag,
   input  word_t      cdb_data,
   input  logic       cdb_valid,

   output lsq_entry_t slot_entry,
   input  logic       slot_accept
);

   lsq_entry_t slot_q;
   lsq_entry_t disp_entry;

   // the dispatch fields packed as a fresh entry
   always_comb begin
      disp_entry.op       = dispatch_op;
      disp_entry.offset   = dispatch_offset;
      disp_entry.rs_tag   = dispatch_rs_tag;
      disp_entry.rt_tag   = dispatch_rt_tag;
      disp_entry.rs_data  = dispatch_rs_data;
      disp_entry.rt_data  = dispatch_rt_data;
      disp_entry.rs_valid = dispatch_rs_valid;
      disp_entry.rt_valid = dispatch_rt_valid;
      disp_entry.valid    = 1'b1;
   end

   // free when empty, or when the queue takes the held entry at this edge
   assign dispatch_ready = !slot_q.valid || slot_accept;

   // a new entry also snoops, so a broadcast in the very cycle of dispatch
   // resolves it on the way in
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot_q <= '0;
      end else if (dispatch_en && dispatch_ready) begin
         slot_q <= cdb_snoop(disp_entry, cdb_tag, cdb_data, cdb_valid);
      end else if (slot_accept) begin
         slot_q.valid <= 1'b0;
      end else begin
         // held entry keeps capturing, empty slot snoops harmlessly
         slot_q <= cdb_snoop(slot_q, cdb_tag, cdb_data, cdb_valid);
      end
   end

   // the queue sees the registered entry and does its own snoop on it
   assign slot_entry = slot_q;

   // the queue may only drain the slot while an entry is held here,
   // otherwise a later dispatch could land on a slot the queue thinks is taken
   a_accept_held: assert property (
      @(posedge clk) disable iff (!rst_n)
      slot_accept |-> slot_q.valid
   );

endmodule

`default_nettype wire

/* logic/load_store_queue.sv */
`timescale 1ns/1ns
`default_nettype none

// in-order load/store queue
// entries shift toward slot 0 and only slot 0 may issue, so no memory
// operation ever passes another one
module load_store_queue import ooo_types_pkg::*, lsq_cfg_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,

   input  lsq_entry_t slot_entry,
   output logic       slot_accept,

   input  tag_t       cdb_tag,
   input  word_t      cdb_data,
   input  logic       cdb_valid,

   mem_issue_if.queue issue
);

   // registered queue slots, index 0 is the oldest
   lsq_entry_t q   [LSQ_DEPTH];
   // slots after this cycle's CDB capture; the top one is the dispatch slot
   lsq_entry_t cur [LSQ_DEPTH+1];
   // next value of every slot
   lsq_entry_t nxt [LSQ_DEPTH];

   logic [LSQ_DEPTH-1:0] do_shift;
   logic                 head_ready;
   logic                 xfer;

   // every entry, including the one in the dispatch slot, captures
   // a matching broadcast in the same cycle it may be shifting
   always_comb begin
      for (int i = 0; i < LSQ_DEPTH; i++) begin
         cur[i] = cdb_snoop(q[i], cdb_tag, cdb_data, cdb_valid);
      end
      cur[LSQ_DEPTH] = cdb_snoop(slot_entry, cdb_tag, cdb_data, cdb_valid);
   end

   // a store needs rs for the address and rt for the data,
   // a load needs only rs
   // readiness comes from the registered head so ready has no path from
   // the CDB and stays steady once raised
   assign head_ready = q[0].valid && q[0].rs_valid &&
                       ((q[0].op == mem_load) || q[0].rt_valid);

   assign xfer = issue.ready && issue.done;

   // an entry moves down one place when the slot below is empty somewhere
   // underneath or the head leaves at this edge
   always_comb begin : shift_calc
      logic full_upto;
      full_upto = 1'b1;
      for (int i = 0; i < LSQ_DEPTH; i++) begin
         full_upto   = full_upto && q[i].valid;
         do_shift[i] = cur[i+1].valid && (xfer || !full_upto);
      end
   end

   // a slot either takes the entry above it, keeps its own, or empties
   // when its own entry moves down (or issues, for slot 0)
   always_comb begin
      for (int i = 0; i < LSQ_DEPTH; i++) begin
         if (do_shift[i]) begin
            nxt[i] = cur[i+1];
         end else begin
            nxt[i] = cur[i];
            if ((i == 0) ? xfer : do_shift[(i == 0) ? 0 : i-1]) begin
               nxt[i].valid = 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < LSQ_DEPTH; i++) begin
            q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < LSQ_DEPTH; i++) begin
            q[i] <= nxt[i];
         end
      end
   end

   // the top slot shifting in means the dispatch slot is drained
   assign slot_accept = do_shift[LSQ_DEPTH-1];

   // the head is offered as is
   // address is base plus sign extended offset, store data is rt
   assign issue.ready  = head_ready;
   assign issue.op     = q[0].op;
   assign issue.rt_tag = q[0].rt_tag;
   assign issue.addr   = q[0].rs_data +
                         {{(XLEN - $bits(offset_t)){q[0].offset[$bits(offset_t)-1]}},
                          q[0].offset};
   assign issue.data   = q[0].rt_data;

   // an offered operation waits with stable fields until the memory unit
   // takes it
   a_ready_held: assert property (
      @(posedge clk) disable iff (!rst_n)
      (issue.ready && !issue.done) |=>
         (issue.ready && $stable(issue.addr) && $stable(issue.data) &&
          $stable(issue.rt_tag) && $stable(issue.op))
   );

   // holes close in one cycle, a valid entry never sits above an empty slot
   for (genvar g = 0; g < LSQ_DEPTH - 1; g++) begin : g_no_hole
      a_hole_closes: assert property (
         @(posedge clk) disable iff (!rst_n)
         (q[g+1].valid && !q[g].valid) |=> q[g].valid
      );
   end

endmodule

`default_nettype wire

/* logic/lsq_cfg_pkg.sv */
`default_nettype none

// sizes and the queue entry layout of the load/store subsystem
package lsq_cfg_pkg;

   import ooo_types_pkg::*;

   // number of shifting slots in the queue, not counting the dispatch slot
   localparam int LSQ_DEPTH = 4;

   // the data RAM is word addressed
   localparam int RAM_WORDS = 256;
   localparam int RAM_IDX_W = 8;

   // cycles from a load's transfer edge to its result
   localparam int LOAD_LAT  = 2;

   // the latency counter must hold LOAD_LAT itself
   localparam int LAT_CNT_W = $clog2(LOAD_LAT + 1);
   typedef logic [LAT_CNT_W-1:0] lat_cnt_t;

   // one waiting load or store with both operands and their readiness
   typedef struct packed {
      mem_op_e op;
      offset_t offset;
      tag_t    rs_tag;
      tag_t    rt_tag;
      word_t   rs_data;
      word_t   rt_data;
      logic    rs_valid;
      logic    rt_valid;
      logic    valid;
   } lsq_entry_t;

   // replaces every unresolved operand of an entry whose tag matches a valid
   // CDB broadcast; operands that are already resolved are never touched
   function automatic lsq_entry_t cdb_snoop(lsq_entry_t e, tag_t tag, word_t data,
                                            logic bcast);
      lsq_entry_t r;
      r = e;
      if (bcast && !e.rs_valid && (e.rs_tag == tag)) begin
         r.rs_data  = data;
         r.rs_valid = 1'b1;
      end
      if (bcast && !e.rt_valid && (e.rt_tag == tag)) begin
         r.rt_data  = data;
         r.rt_valid = 1'b1;
      end
      return r;
   endfunction

endpackage

`default_nettype wire

/* logic/lsq_top.sv */
`timescale 1ns/1ns
`default_nettype none

// memory side of the core: dispatch slot, in-order queue and data memory
// the CDB comes in from outside and load results leave on their own port
module lsq_top import ooo_types_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,

   input  logic    dispatch_en,
   input  mem_op_e dispatch_op,
   input  offset_t dispatch_offset,
   input  tag_t    dispatch_rs_tag,
   input  tag_t    dispatch_rt_tag,
   input  word_t   dispatch_rs_data,
   input  word_t   dispatch_rt_data,
   input  logic    dispatch_rs_valid,
   input  logic    dispatch_rt_valid,
   output logic    dispatch_ready,

   input  tag_t    cdb_tag,
   input  word_t   cdb_data,
   input  logic    cdb_valid,

   output logic    load_valid,
   output tag_t    load_tag,
   output word_t   load_data
);

   lsq_cfg_pkg::lsq_entry_t slot_entry;
   logic                    slot_accept;

   mem_issue_if issue_bus ();

   // both the slot and the queue snoop the CDB on their own entries
   dispatch_slot u_slot (
      .clk               (clk),
      .rst_n             (rst_n),
      .dispatch_en       (dispatch_en),
      .dispatch_op       (dispatch_op),
      .dispatch_offset   (dispatch_offset),
      .dispatch_rs_tag   (dispatch_rs_tag),
      .dispatch_rt_tag   (dispatch_rt_tag),
      .dispatch_rs_data  (dispatch_rs_data),
      .dispatch_rt_data  (dispatch_rt_data),
      .dispatch_rs_valid (dispatch_rs_valid),
      .dispatch_rt_valid (dispatch_rt_valid),
      .dispatch_ready    (dispatch_ready),
      .cdb_tag           (cdb_tag),
      .cdb_data          (cdb_data),
      .cdb_valid         (cdb_valid),
      .slot_entry        (slot_entry),
      .slot_accept       (slot_accept)
   );

   load_store_queue u_queue (
      .clk         (clk),
      .rst_n       (rst_n),
      .slot_entry  (slot_entry),
      .slot_accept (slot_accept),
      .cdb_tag     (cdb_tag),
      .cdb_data    (cdb_data),
      .cdb_valid   (cdb_valid),
      .issue       (issue_bus.queue)
   );

   data_memory_unit u_mem (
      .clk        (clk),
      .rst_n      (rst_n),
      .issue      (issue_bus.mem),
      .load_valid (load_valid),
      .load_tag   (load_tag),
      .load_data  (load_data)
   );

endmodule

`default_nettype wire

/* logic/mem_issue_if.sv */
`timescale 1ns/1ns
`default_nettype none

// one memory operation handed from the queue head to the memory unit
// the operation moves in a cycle where ready and done are both high
interface mem_issue_if import ooo_types_pkg::*; ();

   mem_op_e op;
   // destination tag of a load, passed back with its result
   tag_t    rt_tag;
   // byte address, already word aligned by the program
   word_t   addr;
   // store data, don't care for loads
   word_t   data;
   logic    ready;
   logic    done;

   // the queue offers the head entry
   modport queue (
      output op, rt_tag, addr, data, ready,
      input  done
   );

   // the memory unit takes it when idle
   modport mem (
      input  op, rt_tag, addr, data, ready,
      output done
   );

endinterface

`default_nettype wire

/* logic/ooo_types_pkg.sv */
`default_nettype none

// types shared by every unit of the out-of-order core
// the memory subsystem only sees tags, data words, offsets and the opcode
package ooo_types_pkg;

   // reservation station tags are 6 bits wide across the whole core
   localparam int TAG_W = 6;

   // machine word width
   localparam int XLEN = 32;

   // tag that names the producer of a value still in flight
   typedef logic [TAG_W-1:0] tag_t;

   // one data word as carried on the CDB and in the register file
   typedef logic [XLEN-1:0] word_t;

   // immediate offset of a load or store, sign extended at address generation
   typedef logic signed [15:0] offset_t;

   // loads and stores share one instruction format, so one bit is enough
   typedef enum logic {
      mem_load  = 1'b0,
      mem_store = 1'b1
   } mem_op_e;

endpackage

`default_nettype wire

/* sim.f */
logic/ooo_types_pkg.sv
logic/lsq_cfg_pkg.sv
logic/mem_issue_if.sv
logic/dispatch_slot.sv
logic/load_store_queue.sv
logic/data_memory_unit.sv
logic/lsq_top.sv
verification/lsq_tb.sv

/* verification/lsq_tb.sv */
`timescale 1ns/1ns
`default_nettype none

// directed testbench for the load/store subsystem
// a word model predicts every load and results are checked in dispatch order
module lsq_tb import ooo_types_pkg::*, lsq_cfg_pkg::*; ();

   localparam int CLK_PERIOD = 8;
   localparam int RST_CYCLES = 10;
   // instructions dispatched over all tests, this sizes the watchdog
   localparam int N_DISPATCH = 83;
   localparam int N_RANDOM   = 60;
   localparam int POOL_WORDS = 8;
   localparam logic [31:0] POOL_BASE = 32'h200;

   logic    clk;
   logic    rst_n;
   logic    dispatch_en;
   mem_op_e dispatch_op;
   offset_t dispatch_offset;
   tag_t    dispatch_rs_tag;
   tag_t    dispatch_rt_tag;
   word_t   dispatch_rs_data;
   word_t   dispatch_rt_data;
   logic    dispatch_rs_valid;
   logic    dispatch_rt_valid;
   logic    dispatch_ready;
   tag_t    cdb_tag;
   word_t   cdb_data;
   logic    cdb_valid;
   logic    load_valid;
   tag_t    load_tag;
   word_t   load_data;

   // counts rising edges, cycle c starts at the c-th edge
   int cyc = 0;

   // word model indexed by word address, updated in program order
   word_t mem_model [int];
   // load results still owed by the DUT, oldest first
   tag_t  exp_tag [$];
   word_t exp_data [$];
   int    n_results = 0;

   // broadcasts waiting for their turn on the CDB
   tag_t  pend_tag [$];
   word_t pend_data [$];
   int    pend_due [$];
   // the broadcast picked for the coming cycle
   tag_t  staged_tag;
   word_t staged_data;
   logic  staged_go = 1'b0;

   int next_tag = 0;
   int err_cnt  = 0;

   lsq_top UUT (
      .clk               (clk),
      .rst_n             (rst_n),
      .dispatch_en       (dispatch_en),
      .dispatch_op       (dispatch_op),
      .dispatch_offset   (dispatch_offset),
      .dispatch_rs_tag   (dispatch_rs_tag),
      .dispatch_rt_tag   (dispatch_rt_tag),
      .dispatch_rs_data  (dispatch_rs_data),
      .dispatch_rt_data  (dispatch_rt_data),
      .dispatch_rs_valid (dispatch_rs_valid),
      .dispatch_rt_valid (dispatch_rt_valid),
      .dispatch_ready    (dispatch_ready),
      .cdb_tag           (cdb_tag),
      .cdb_data          (cdb_data),
      .cdb_valid         (cdb_valid),
      .load_valid        (load_valid),
      .load_tag          (load_tag),
      .load_data         (load_data)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   task automatic fail_run(input string msg);
      err_cnt++;
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_tag(input string name, input tag_t got, input tag_t exp);
      if (got !== exp) begin
         fail_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         fail_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
      end
   endtask

   // hands out tags round robin, skipping any tag that a waiting or
   // current broadcast still uses
   task automatic new_tag(output tag_t t);
      logic busy;
      busy = 1'b1;
      while (busy) begin
         next_tag = (next_tag % 63) + 1;
         t = tag_t'(next_tag);
         busy = (staged_go && staged_tag == t) || (cdb_valid === 1'b1 && cdb_tag == t);
         foreach (pend_tag[k]) begin
            if (pend_tag[k] == t) begin
               busy = 1'b1;
            end
         end
      end
   endtask

   // queue a broadcast for the next cycle plus delay extra cycles
   task automatic schedule_bcast(input tag_t t, input word_t d, input int delay);
      pend_tag.push_back(t);
      pend_data.push_back(d);
      pend_due.push_back(cyc + 1 + delay);
   endtask

   // every test task starts and ends 1 ns after a rising edge
   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
      end
      #1;
   endtask

   task automatic wait_drain();
      while (exp_tag.size() != 0 || pend_tag.size() != 0) begin
         wait_cycles(1);
      end
   endtask

   // predicts the instruction in the model, then holds it on the dispatch
   // port until the DUT takes it
   // for a load, data_tag is the destination tag
   task automatic send_mem_op(input mem_op_e op, input offset_t off, input word_t base,
                              input word_t sdata, input logic base_rdy,
                              input logic data_rdy, input tag_t base_tag,
                              input tag_t data_tag);
      word_t addr;
      int    idx;
      addr = base + word_t'(int'(off));
      idx  = int'(addr >> 2);
      if (op == mem_store) begin
         mem_model[idx] = sdata;
      end else begin
         if (!mem_model.exists(idx)) begin
            fail_run($sformatf("test error: load from 0x%0h, a word never stored", addr));
         end
         exp_tag.push_back(data_tag);
         exp_data.push_back(mem_model[idx]);
      end
      dispatch_en      = 1'b1;
      dispatch_op      = op;
      dispatch_offset  = off;
      dispatch_rs_tag  = base_tag;
      dispatch_rt_tag  = data_tag;
      // unresolved operands carry junk so only a captured broadcast works
      dispatch_rs_data = base_rdy ? base : ~base;
      dispatch_rt_data = (op == mem_load) ? '0 : (data_rdy ? sdata : ~sdata);
      dispatch_rs_valid = base_rdy;
      // a load never waits on its destination
      dispatch_rt_valid = (op == mem_load) || data_rdy;
      @(negedge clk);
      while (!dispatch_ready) begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      dispatch_en = 1'b0;
   endtask

   // picks one due broadcast at the falling edge and drives it after the
   // next rising edge, one per cycle in queue order
   initial begin : cdb_driver
      int pick;
      cdb_valid = 1'b0;
      cdb_tag   = '0;
      cdb_data  = '0;
      forever begin
         @(negedge clk);
         pick = -1;
         for (int k = 0; k < pend_due.size(); k++) begin
            if (pick < 0 && pend_due[k] <= cyc + 1) begin
               pick = k;
            end
         end
         staged_go = (pick >= 0);
         if (pick >= 0) begin
            staged_tag  = pend_tag[pick];
            staged_data = pend_data[pick];
            pend_tag.delete(pick);
            pend_data.delete(pick);
            pend_due.delete(pick);
         end
         @(posedge clk);
         #1;
         cdb_valid = staged_go;
         cdb_tag   = staged_go ? staged_tag : '0;
         if (staged_go) begin
            cdb_data = staged_data;
         end
         staged_go = 1'b0;
      end
   end

   // load results are pulses, so each one is seen at exactly one falling edge
   initial begin : result_monitor
      tag_t  e_tag;
      word_t e_data;
      forever begin
         @(negedge clk);
         if (rst_n === 1'b1 && load_valid !== 1'b0) begin
            check_bit("load_valid", load_valid, 1'b1);
            if (exp_tag.size() == 0) begin
               fail_run($sformatf("load result with tag 0x%0h came with no load waiting",
                                  load_tag));
            end
            e_tag  = exp_tag.pop_front();
            e_data = exp_data.pop_front();
            check_tag("load_tag", load_tag, e_tag);
            check_word("load_data", load_data, e_data);
            n_results++;
         end
      end
   end

   initial begin : watchdog
      #((RST_CYCLES + 200 * N_DISPATCH) * CLK_PERIOD);
      fail_run("timeout: the DUT stopped returning results before the tests ended");
   end

   task automatic test_reset_state();
      @(negedge clk);
      check_bit("dispatch_ready", dispatch_ready, 1'b1);
      check_bit("load_valid", load_valid, 1'b0);
      @(posedge clk);
      #1;
   endtask

   // different base and offset pairs meet on one word, including the most
   // negative offset
   task automatic test_store_then_load();
      tag_t t_rs;
      tag_t t_rt;
      new_tag(t_rs);
      new_tag(t_rt);
      send_mem_op(mem_store, offset_t'(16), 32'h30, 32'hcafe_0001, 1'b1, 1'b1, t_rs, t_rt);
      new_tag(t_rs);
      new_tag(t_rt);
      send_mem_op(mem_load, offset_t'(-16), 32'h50, '0, 1'b1, 1'b1, t_rs, t_rt);
      new_tag(t_rs);
      new_tag(t_rt);
      send_mem_op(mem_store, offset_t'(-4), 32'h100, 32'h1234_5678, 1'b1, 1'b1, t_rs, t_rt);
      new_tag(t_rs);
      new_tag(t_rt);
      send_mem_op(mem_load, offset_t'(-32768), 32'h80fc, '0, 1'b1, 1'b1, t_rs, t_rt);
      wait_drain();
   endtask

   task automatic test_wait_for_base();
      tag_t t_rs;
      tag_t t_rt;
      int   seen;
      // word 0x40 already holds the first store
      new_tag(t_rs);
      new_tag(t_rt);
      send_mem_op(mem_load, offset_t'(8), 32'h38, '0, 1'b0, 1'b1, t_rs, t_rt);
      seen = n_results;
      wait_cycles(12);
      if (n_results != seen) begin
         fail_run("a load returned before its base operand was broadcast");
      end
      schedule_bcast(t_rs, 32'h38, 0);
      wait_drain();
      new_tag(t_rs);
      new_tag(t_rt);
      send_mem_op(mem_store, offset_t'(0), 32'h140, 32'h0bad_f00d, 1'b1, 1'b1, t_rs, t_rt);
      // the base goes out on the CDB in the very cycle the load is offered
      new_tag(t_rs);
      new_tag(t_rt);
      schedule_bcast(t_rs, 32'h148, 0);
      wait_cycles(1);
      send_mem_op(mem_load, offset_t'(-8), 32'h148, '0, 1'b0, 1'b1, t_rs, t_rt);
      wait_drain();
   endtask

   task automatic test_store_blocks_load();
      tag_t t_rs;
      tag_t t_rt;
      tag_t t_wait;
      int   seen;
      new_tag(t_rs);
      new_tag(t_rt);
      send_mem_op(mem_store, offset_t'(0), 32'h80, 32'h1111_1111, 1'b1, 1'b1, t_rs, t_rt);
      // this store waits on its data, the load behind it must wait too
      new_tag(t_rs);
      new_tag(t_wait);
      send_mem_op(mem_store, offset_t'(4), 32'h7c, 32'h2222_2222, 1'b1, 1'b0, t_rs, t_wait);
      new_tag(t_rs);
      new_tag(t_rt);
      send_mem_op(mem_load, offset_t'(0), 32'h80, '0, 1'b1, 1'b1, t_rs, t_rt);
      seen = n_results;
      wait_cycles(12);
      if (n_results != seen) begin
         fail_run("a load passed an older store that was still waiting for its data");
      end
      schedule_bcast(t_wait, 32'h2222_2222, 0);
      wait_drain();
   endtask

   task automatic test_back_pressure();
      tag_t  t_rs [LSQ_DEPTH+1];
      word_t base [LSQ_DEPTH+1];
      tag_t  t_rt;
      word_t addr;
      int    seen;
      seen = n_results;
      for (int i = 0; i <= LSQ_DEPTH; i++) begin
         addr    = (i % 2 == 0) ? 32'h40 : 32'hfc;
         base[i] = addr + 32'd8 - word_t'(4 * i);
         new_tag(t_rs[i]);
         new_tag(t_rt);
         send_mem_op(mem_load, offset_t'(4 * i - 8), base[i], '0, 1'b0, 1'b1, t_rs[i], t_rt);
      end
      // queue and slot are full, nothing can issue
      wait_cycles(3);
      @(negedge clk);
      check_bit("dispatch_ready", dispatch_ready, 1'b0);
      @(posedge clk);
      #1;
      if (n_results != seen) begin
         fail_run("a load returned while its base operand was still missing");
      end
      // youngest base first, results must still come back oldest first
      for (int i = LSQ_DEPTH; i >= 0; i--) begin
         schedule_bcast(t_rs[i], base[i], LSQ_DEPTH - i);
      end
      wait_drain();
   endtask

   task automatic test_random_stream();
      tag_t    t_rs;
      tag_t    t_rt;
      mem_op_e op;
      offset_t off;
      word_t   addr;
      word_t   base;
      word_t   sdata;
      logic    rs_rdy;
      logic    rt_rdy;
      // every pool word gets a known value before random loads touch it
      for (int k = 0; k < POOL_WORDS; k++) begin
         new_tag(t_rs);
         new_tag(t_rt);
         send_mem_op(mem_store, offset_t'(0), POOL_BASE + word_t'(4 * k), $urandom,
                     1'b1, 1'b1, t_rs, t_rt);
      end
      for (int n = 0; n < N_RANDOM; n++) begin
         op     = ($urandom_range(0, 1) == 1) ? mem_store : mem_load;
         addr   = POOL_BASE + word_t'(4 * $urandom_range(0, POOL_WORDS - 1));
         off    = offset_t'((int'($urandom_range(0, 32)) - 16) * 4);
         base   = addr - word_t'(int'(off));
         sdata  = $urandom;
         rs_rdy = $urandom_range(0, 1);
         rt_rdy = $urandom_range(0, 1);
         new_tag(t_rs);
         new_tag(t_rt);
         send_mem_op(op, off, base, sdata, rs_rdy, rt_rdy, t_rs, t_rt);
         if (!rs_rdy) begin
            schedule_bcast(t_rs, base, $urandom_range(0, 6));
         end
         if (op == mem_store && !rt_rdy) begin
            schedule_bcast(t_rt, sdata, $urandom_range(0, 6));
         end
         // idle gaps now and then let the queue run dry
         if ($urandom_range(0, 3) == 0) begin
            wait_cycles($urandom_range(1, 4));
         end
      end
      wait_drain();
   endtask

   initial begin : main
      void'($urandom(32'h10));
      rst_n             = 1'b0;
      dispatch_en       = 1'b0;
      dispatch_op       = mem_load;
      dispatch_offset   = '0;
      dispatch_rs_tag   = '0;
      dispatch_rt_tag   = '0;
      dispatch_rs_data  = '0;
      dispatch_rt_data  = '0;
      dispatch_rs_valid = 1'b0;
      dispatch_rt_valid = 1'b0;
      repeat (RST_CYCLES) begin
         @(posedge clk);
      end
      #1;
      rst_n = 1'b1;
      test_reset_state();
      test_store_then_load();
      test_wait_for_base();
      test_store_blocks_load();
      test_back_pressure();
      test_random_stream();
      if (err_cnt == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("Simulation finished: FAIL");
         $fatal(1, "errors were found");
      end
   end

endmodule

`default_nettype wire
